// File: hdl/stripe_pkg.sv
package stripe_pkg;

  // the caller addresses whole data words, never bytes
  typedef logic [19:0] word_addr_t;

  // a bank holds every second word, so its address drops the low bit
  typedef logic [18:0] bank_addr_t;

  typedef logic [15:0] data_t;

  // zero based beat count, so a value of 0 asks for a single beat
  typedef logic [7:0] lenw_t;

  // one bit wider than lenw_t so that lenw plus one still fits
  typedef logic [$bits(lenw_t):0] beats_t;

  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  // even words sit in bank 0 and odd words in bank 1
  localparam int NUM_BANKS = 2;

  // each bank reader buffers up to 16 results
  localparam int RES_FIFO_DEPTH_LOG2 = 4;

  // a reader stops issuing once fewer than this many result slots are free
  localparam int RES_FIFO_ALMOST_FULL_BUF = 4;

  // wide enough to count every entry of a result FIFO
  typedef logic [RES_FIFO_DEPTH_LOG2:0] fifo_cnt_t;

  // IDLE waits for a command, ISSUE sends bank reads, DRAIN waits for the last pop
  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    DRAIN
  } reader_state_t;

endpackage

// File: hdl/stripe_if.sv
`timescale 1ns/100ps

// command broadcast from the sequencer to both bank readers
interface burst_cmd_if import stripe_pkg::*; ();
  word_addr_t start;
  lenw_t      lenw;
  logic       valid;

  // each reader drives the element picked by its own bank number
  logic       ready [NUM_BANKS];
  logic       ready_0;
  logic       ready_1;

  // named copies so the sequencer sees one line per bank
  assign ready_0 = ready[0];
  assign ready_1 = ready[1];

  modport sequencer(output start, output lenw, output valid, input ready_0, input ready_1);
  modport reader(input start, input lenw, input valid, output ready);
endinterface

// result stream from one bank reader FIFO head into the sequencer
interface bank_rd_if import stripe_pkg::*; ();
  data_t data;
  resp_t resp;
  logic  valid;
  logic  ready;

  modport reader(output data, output resp, output valid, input ready);
  modport sequencer(input data, input resp, input valid, output ready);
endinterface

// File: hdl/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo import stripe_pkg::*; #(
  parameter int WIDTH      = 8,
  parameter int DEPTH_LOG2 = 4
) (
  input  logic             axi_clk,
  input  logic             axi_resetn,
  input  logic             w_inc,
  input  logic [WIDTH-1:0] w_data,
  output logic             almost_full,
  input  logic             r_inc,
  output logic [WIDTH-1:0] r_data,
  output logic             empty
);

  logic [WIDTH-1:0]    mem [2**DEPTH_LOG2];

  // the extra top bit tells a full buffer apart from an empty one
  logic [DEPTH_LOG2:0] w_ptr;
  logic [DEPTH_LOG2:0] r_ptr;
  logic [DEPTH_LOG2:0] used;
  logic [DEPTH_LOG2:0] free;

  // occupancy falls out of the pointer difference, wrap included
  assign used = w_ptr - r_ptr;

  // the constant is the full depth, a one in the top pointer bit
  assign free = {1'b1, {DEPTH_LOG2{1'b0}}} - used;

  // writers look at this before they commit to more data
  assign almost_full = (free < (DEPTH_LOG2 + 1)'(RES_FIFO_ALMOST_FULL_BUF));

  assign empty = (w_ptr == r_ptr);

  // head of the queue is visible at once, so a pop needs no read latency
  assign r_data = mem[r_ptr[DEPTH_LOG2-1:0]];

  always_ff @(posedge axi_clk) begin
    if (w_inc) begin
      mem[w_ptr[DEPTH_LOG2-1:0]] <= w_data;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      w_ptr <= '0;
      r_ptr <= '0;
    end else begin
      // writers never push into a full buffer and readers never pop an empty one
      if (w_inc) begin
        w_ptr <= w_ptr + 1'b1;
      end
      if (r_inc) begin
        r_ptr <= r_ptr + 1'b1;
      end
    end
  end

endmodule

// File: hdl/bank_reader.sv
`timescale 1ns/100ps

module bank_reader import stripe_pkg::*; #(
  parameter bit BANK_SEL = 1'b0
) (
  input  logic        axi_clk,
  input  logic        axi_resetn,
  burst_cmd_if.reader cmd,
  bank_rd_if.reader   rd,
  output bank_addr_t  bank_araddr,
  output logic        bank_arvalid,
  input  logic        bank_arready,
  input  data_t       bank_rdata,
  input  resp_t       bank_rresp,
  input  logic        bank_rvalid,
  output logic        bank_rready
);

  reader_state_t state;

  // bank address of the next read still to be issued
  bank_addr_t next_addr;

  // reads not yet issued and words not yet popped for the current burst
  beats_t     issue_left;
  beats_t     pop_left;

  // reads issued whose response has not come back yet
  fifo_cnt_t  pending;

  logic       cmd_take;
  logic       start_match;
  bank_addr_t first_addr;
  beats_t     share;
  logic       issue;
  logic       beat_return;
  logic       beat_pop;
  logic       fifo_almost_full;
  logic       fifo_empty;
  logic [$bits(resp_t)+$bits(data_t)-1:0] fifo_w_data;
  logic [$bits(resp_t)+$bits(data_t)-1:0] fifo_r_data;

  // ready stays low from the taken command until the last word of our share pops
  assign cmd.ready[BANK_SEL] = (state == IDLE);
  assign cmd_take = cmd.valid && (state == IDLE);

  // true when the first word of the burst already lives in this bank
  assign start_match = (cmd.start[0] == BANK_SEL);

  // only bank 0 with an odd start has to skip ahead to the next bank row
  assign first_addr = cmd.start[$bits(word_addr_t)-1:1] +
                      bank_addr_t'(!start_match && !BANK_SEL);

  // our share is half the beats, rounded up when the burst starts here
  assign share = (beats_t'(cmd.lenw) + beats_t'(start_match) + beats_t'(1)) >> 1;

  // reads in flight count against the free slots, so returns always fit
  assign issue = (state == ISSUE) &&
                 (issue_left != '0) &&
                 !fifo_almost_full &&
                 (pending < fifo_cnt_t'(RES_FIFO_ALMOST_FULL_BUF)) &&
                 (!bank_arvalid || bank_arready);

  assign beat_return = bank_rvalid && bank_rready;
  assign beat_pop = rd.valid && rd.ready;

  // the in-flight limit guarantees FIFO space for every response
  assign bank_rready = 1'b1;

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      state      <= IDLE;
      issue_left <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (cmd_take) begin
            issue_left <= share;
            // an empty share goes straight to waiting, which ends at once
            state <= (share == '0) ? DRAIN : ISSUE;
          end
        end
        ISSUE: begin
          if (issue) begin
            issue_left <= issue_left - beats_t'(1);
          end
          if (issue_left == '0) begin
            state <= DRAIN;
          end
        end
        DRAIN: begin
          if (pop_left == '0) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      pop_left <= '0;
    end else if (cmd_take) begin
      pop_left <= share;
    end else if (beat_pop) begin
      pop_left <= pop_left - beats_t'(1);
    end
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      pending <= '0;
    end else begin
      case ({issue, beat_return})
        2'b10:   pending <= pending + fifo_cnt_t'(1);
        2'b01:   pending <= pending - fifo_cnt_t'(1);
        default: pending <= pending;
      endcase
    end
  end

  // arvalid holds until accepted, a new read may follow on the same edge
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      bank_arvalid <= 1'b0;
    end else if (issue) begin
      bank_arvalid <= 1'b1;
    end else if (bank_arready) begin
      bank_arvalid <= 1'b0;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (cmd_take) begin
      next_addr <= first_addr;
    end else if (issue) begin
      next_addr   <= next_addr + bank_addr_t'(1);
      bank_araddr <= next_addr;
    end
  end

  // responses come back in order, so the FIFO keeps word order too
  assign fifo_w_data = {bank_rresp, bank_rdata};

  sync_fifo #(
    .WIDTH      ($bits(resp_t) + $bits(data_t)),
    .DEPTH_LOG2 (RES_FIFO_DEPTH_LOG2)
  ) u_res_fifo (
    .axi_clk     (axi_clk),
    .axi_resetn  (axi_resetn),
    .w_inc       (beat_return),
    .w_data      (fifo_w_data),
    .almost_full (fifo_almost_full),
    .r_inc       (beat_pop),
    .r_data      (fifo_r_data),
    .empty       (fifo_empty)
  );

  assign rd.valid = !fifo_empty;
  assign {rd.resp, rd.data} = fifo_r_data;

endmodule

// File: hdl/stripe_sequencer.sv
`timescale 1ns/100ps

module stripe_sequencer import stripe_pkg::*; (
  input  logic           axi_clk,
  input  logic           axi_resetn,
  input  word_addr_t     in_araddr,
  input  lenw_t          in_arlenw,
  input  logic           in_arvalid,
  output logic           in_arready,
  output data_t          in_rdata,
  output resp_t          in_rresp,
  output logic           in_rvalid,
  output logic           in_rlast,
  input  logic           in_rready,
  burst_cmd_if.sequencer cmd,
  bank_rd_if.sequencer   rd0,
  bank_rd_if.sequencer   rd1
);

  word_addr_t req_start;
  lenw_t      req_lenw;
  logic       cmd_valid;

  // remembers which reader has already taken the current command
  logic       taken_0;
  logic       taken_1;
  logic       got_0;
  logic       got_1;

  // word address of the next beat to merge and the beats still owed
  word_addr_t cur_addr;
  beats_t     beats_left;

  logic       req_accept;
  logic       sel_valid;
  data_t      sel_data;
  resp_t      sel_resp;
  logic       pop;

  assign req_accept = in_arvalid && in_arready;

  // a single caller request at a time, released by the rlast handshake
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      in_arready <= 1'b1;
    end else if (req_accept) begin
      in_arready <= 1'b0;
    end else if (in_rvalid && in_rready && in_rlast) begin
      in_arready <= 1'b1;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (req_accept) begin
      req_start <= in_araddr;
      req_lenw  <= in_arlenw;
    end
  end

  assign got_0 = taken_0 || cmd.ready_0;
  assign got_1 = taken_1 || cmd.ready_1;

  // the broadcast stays up until each reader has seen it with its ready high
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      cmd_valid <= 1'b0;
      taken_0   <= 1'b0;
      taken_1   <= 1'b0;
    end else if (req_accept) begin
      cmd_valid <= 1'b1;
      taken_0   <= 1'b0;
      taken_1   <= 1'b0;
    end else if (cmd_valid) begin
      taken_0 <= got_0;
      taken_1 <= got_1;
      if (got_0 && got_1) begin
        cmd_valid <= 1'b0;
      end
    end
  end

  assign cmd.valid = cmd_valid;
  assign cmd.start = req_start;
  assign cmd.lenw  = req_lenw;

  // word parity names the bank that holds the next beat
  assign sel_valid = cur_addr[0] ? rd1.valid : rd0.valid;
  assign sel_data  = cur_addr[0] ? rd1.data : rd0.data;
  assign sel_resp  = cur_addr[0] ? rd1.resp : rd0.resp;

  // merge only while the output register is free or being emptied this edge
  assign pop = (beats_left != '0) && sel_valid && (!in_rvalid || in_rready);

  assign rd0.ready = pop && !cur_addr[0];
  assign rd1.ready = pop && cur_addr[0];

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      cur_addr   <= '0;
      beats_left <= '0;
    end else if (req_accept) begin
      cur_addr   <= in_araddr;
      beats_left <= beats_t'(in_arlenw) + beats_t'(1);
    end else if (pop) begin
      cur_addr   <= cur_addr + word_addr_t'(1);
      beats_left <= beats_left - beats_t'(1);
    end
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      in_rvalid <= 1'b0;
    end else if (pop) begin
      in_rvalid <= 1'b1;
    end else if (in_rready) begin
      in_rvalid <= 1'b0;
    end
  end

  // the beat popped while one beat is still owed is the last of the burst
  always_ff @(posedge axi_clk) begin
    if (pop) begin
      in_rdata <= sel_data;
      in_rresp <= sel_resp;
      in_rlast <= (beats_left == beats_t'(1));
    end
  end

endmodule

// File: hdl/striped_reader.sv
`timescale 1ns/100ps

module striped_reader import stripe_pkg::*; (
  input  logic       axi_clk,
  input  logic       axi_resetn,

  // caller request and result channels
  input  word_addr_t in_araddr,
  input  lenw_t      in_arlenw,
  input  logic       in_arvalid,
  output logic       in_arready,
  output data_t      in_rdata,
  output resp_t      in_rresp,
  output logic       in_rvalid,
  output logic       in_rlast,
  input  logic       in_rready,

  // bank 0 holds the even word addresses
  output bank_addr_t bank0_araddr,
  output logic       bank0_arvalid,
  input  logic       bank0_arready,
  input  data_t      bank0_rdata,
  input  resp_t      bank0_rresp,
  input  logic       bank0_rvalid,
  output logic       bank0_rready,

  // bank 1 holds the odd word addresses
  output bank_addr_t bank1_araddr,
  output logic       bank1_arvalid,
  input  logic       bank1_arready,
  input  data_t      bank1_rdata,
  input  resp_t      bank1_rresp,
  input  logic       bank1_rvalid,
  output logic       bank1_rready
);

  burst_cmd_if u_cmd ();
  bank_rd_if   u_rd0 ();
  bank_rd_if   u_rd1 ();

  stripe_sequencer u_sequencer (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .in_araddr  (in_araddr),
    .in_arlenw  (in_arlenw),
    .in_arvalid (in_arvalid),
    .in_arready (in_arready),
    .in_rdata   (in_rdata),
    .in_rresp   (in_rresp),
    .in_rvalid  (in_rvalid),
    .in_rlast   (in_rlast),
    .in_rready  (in_rready),
    .cmd        (u_cmd.sequencer),
    .rd0        (u_rd0.sequencer),
    .rd1        (u_rd1.sequencer)
  );

  bank_reader #(
    .BANK_SEL (1'b0)
  ) u_bank0 (
    .axi_clk      (axi_clk),
    .axi_resetn   (axi_resetn),
    .cmd          (u_cmd.reader),
    .rd           (u_rd0.reader),
    .bank_araddr  (bank0_araddr),
    .bank_arvalid (bank0_arvalid),
    .bank_arready (bank0_arready),
    .bank_rdata   (bank0_rdata),
    .bank_rresp   (bank0_rresp),
    .bank_rvalid  (bank0_rvalid),
    .bank_rready  (bank0_rready)
  );

  bank_reader #(
    .BANK_SEL (1'b1)
  ) u_bank1 (
    .axi_clk      (axi_clk),
    .axi_resetn   (axi_resetn),
    .cmd          (u_cmd.reader),
    .rd           (u_rd1.reader),
    .bank_araddr  (bank1_araddr),
    .bank_arvalid (bank1_arvalid),
    .bank_arready (bank1_arready),
    .bank_rdata   (bank1_rdata),
    .bank_rresp   (bank1_rresp),
    .bank_rvalid  (bank1_rvalid),
    .bank_rready  (bank1_rready)
  );

endmodule

// File: testbench/striped_reader_chk.sv
`timescale 1ns/100ps

module striped_reader_chk import stripe_pkg::*; (
  input logic       axi_clk,
  input logic       axi_resetn,
  input logic       in_arvalid,
  input logic       in_arready,
  input data_t      in_rdata,
  input resp_t      in_rresp,
  input logic       in_rvalid,
  input logic       in_rlast,
  input logic       in_rready,
  input bank_addr_t bank0_araddr,
  input logic       bank0_arvalid,
  input logic       bank0_arready,
  input bank_addr_t bank1_araddr,
  input logic       bank1_arvalid,
  input logic       bank1_arready
);

  // a result beat that is not taken stays put with the same payload
  a_rvalid_hold: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    in_rvalid && !in_rready |=> in_rvalid && $stable({in_rdata, in_rresp, in_rlast}))
    else $error("in_rvalid or its payload changed while in_rready was low");

  // each bank read request holds its address until the bank accepts it
  a_bank0_ar_hold: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    bank0_arvalid && !bank0_arready |=> bank0_arvalid && $stable(bank0_araddr))
    else $error("bank0 read request changed before bank0_arready");

  a_bank1_ar_hold: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    bank1_arvalid && !bank1_arready |=> bank1_arvalid && $stable(bank1_araddr))
    else $error("bank1 read request changed before bank1_arready");

  // only one caller request at a time, so ready drops right after an accept
  a_arready_drops: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    in_arvalid && in_arready |=> !in_arready)
    else $error("in_arready stayed high after a request was accepted");

  // and it stays low until the beat with rlast has been handed over
  a_arready_waits: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    !in_arready && !(in_rvalid && in_rready && in_rlast) |=> !in_arready)
    else $error("in_arready rose before the rlast handshake");

endmodule

// File: testbench/striped_reader_tb.sv
`timescale 1ns/100ps

// one bank behind a single-beat read port, with random ready and response delays
module bank_model import stripe_pkg::*; #(
  parameter bit BANK_NUM = 1'b0
) (
  input  logic       axi_clk,
  input  word_addr_t err_addr,
  input  bank_addr_t araddr,
  input  logic       arvalid,
  output logic       arready,
  output data_t      rdata,
  output resp_t      rresp,
  output logic       rvalid,
  input  logic       rready
);

  // addresses accepted but not yet answered, oldest first
  bank_addr_t  pend_q[$];
  int          ar_wait;
  int          r_wait;
  logic        ar_hs;
  logic        r_hs;
  bank_addr_t  ar_addr;
  word_addr_t  waddr;
  logic [31:0] wide;

  initial begin
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
    rresp   = RESP_OKAY;
    ar_wait = 0;
    r_wait  = 0;
    forever begin
      // the values seen here are the ones the next rising edge acts on
      @(negedge axi_clk);
      ar_hs   = arvalid && arready;
      ar_addr = araddr;
      r_hs    = rvalid && rready;
      @(posedge axi_clk);
      #1;
      if (r_hs) begin
        void'(pend_q.pop_front());
        r_wait = $urandom_range(3, 0);
      end
      if (ar_hs) begin
        pend_q.push_back(ar_addr);
        ar_wait = $urandom_range(3, 0);
      end else if (ar_wait > 0) begin
        ar_wait--;
      end
      arready = (ar_wait == 0);
      // a response only moves on once the current one has been taken
      if (r_hs || !rvalid) begin
        if (pend_q.size() > 0 && r_wait == 0) begin
          waddr  = {pend_q[0], BANK_NUM};
          wide   = 32'(waddr) * 32'd3 + 32'd1;
          rdata  = wide[15:0];
          rresp  = (waddr == err_addr) ? RESP_SLVERR : RESP_OKAY;
          rvalid = 1'b1;
        end else begin
          rvalid = 1'b0;
          if (r_wait > 0) begin
            r_wait--;
          end
        end
      end
    end
  end

endmodule

module striped_reader_tb import stripe_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 2000;

  logic       axi_clk;
  logic       axi_resetn;
  word_addr_t in_araddr;
  lenw_t      in_arlenw;
  logic       in_arvalid;
  logic       in_arready;
  data_t      in_rdata;
  resp_t      in_rresp;
  logic       in_rvalid;
  logic       in_rlast;
  logic       in_rready;
  bank_addr_t bank0_araddr;
  logic       bank0_arvalid;
  logic       bank0_arready;
  data_t      bank0_rdata;
  resp_t      bank0_rresp;
  logic       bank0_rvalid;
  logic       bank0_rready;
  bank_addr_t bank1_araddr;
  logic       bank1_arvalid;
  logic       bank1_arready;
  data_t      bank1_rdata;
  resp_t      bank1_rresp;
  logic       bank1_rvalid;
  logic       bank1_rready;

  // word address that both bank models answer with SLVERR
  word_addr_t err_addr;

  striped_reader u_striped_reader (.*);

  bank_model #(.BANK_NUM(1'b0)) u_bank0_model (
    .axi_clk (axi_clk), .err_addr (err_addr),
    .araddr (bank0_araddr), .arvalid (bank0_arvalid), .arready (bank0_arready),
    .rdata (bank0_rdata), .rresp (bank0_rresp), .rvalid (bank0_rvalid), .rready (bank0_rready)
  );

  bank_model #(.BANK_NUM(1'b1)) u_bank1_model (
    .axi_clk (axi_clk), .err_addr (err_addr),
    .araddr (bank1_araddr), .arvalid (bank1_arvalid), .arready (bank1_arready),
    .rdata (bank1_rdata), .rresp (bank1_rresp), .rvalid (bank1_rvalid), .rready (bank1_rready)
  );

  bind striped_reader striped_reader_chk u_chk (
    .axi_clk (axi_clk), .axi_resetn (axi_resetn),
    .in_arvalid (in_arvalid), .in_arready (in_arready),
    .in_rdata (in_rdata), .in_rresp (in_rresp), .in_rvalid (in_rvalid),
    .in_rlast (in_rlast), .in_rready (in_rready),
    .bank0_araddr (bank0_araddr), .bank0_arvalid (bank0_arvalid),
    .bank0_arready (bank0_arready), .bank1_araddr (bank1_araddr),
    .bank1_arvalid (bank1_arvalid), .bank1_arready (bank1_arready)
  );

  initial begin
    axi_clk = 1'b0;
    forever #4 axi_clk = ~axi_clk;
  end

  // every word in the banks holds its own address times three plus one
  function automatic data_t word_value(input word_addr_t addr);
    logic [31:0] prod;
    prod = 32'(addr) * 32'd3 + 32'd1;
    return prod[15:0];
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_data(input data_t got, input data_t exp, input string name);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_resp(input resp_t got, input resp_t exp, input string name);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_last(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input int got, input int exp, input string name);
    if (got != exp) begin
      abort_run($sformatf("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  // runs one request and checks every beat, entered and left just after a rising edge
  task automatic run_burst(input word_addr_t start, input lenw_t lenw,
                           input word_addr_t err, input int stall_pct);
    int         cycles;
    int         beat;
    int         reads0;
    int         reads1;
    int         evens;
    logic       accepted;
    word_addr_t addr;
    err_addr   = err;
    in_araddr  = start;
    in_arlenw  = lenw;
    in_arvalid = 1'b1;
    cycles     = 0;
    accepted   = 1'b0;
    while (!accepted) begin
      @(negedge axi_clk);
      accepted = in_arready;
      @(posedge axi_clk);
      #1;
      cycles++;
      if (!accepted && cycles > TIMEOUT_CYCLES) begin
        abort_run("timed out waiting for in_arready to accept a request");
      end
    end
    in_arvalid = 1'b0;
    in_rready  = ($urandom_range(99, 0) >= stall_pct);
    beat   = 0;
    cycles = 0;
    reads0 = 0;
    reads1 = 0;
    while (beat <= int'(lenw)) begin
      @(negedge axi_clk);
      // bank responses are always accepted at once
      check_last(bank0_rready, 1'b1, "bank0_rready");
      check_last(bank1_rready, 1'b1, "bank1_rready");
      if (bank0_arvalid && bank0_arready) begin
        reads0++;
      end
      if (bank1_arvalid && bank1_arready) begin
        reads1++;
      end
      if (in_rvalid && in_rready) begin
        addr = start + word_addr_t'(beat);
        check_data(in_rdata, word_value(addr), "in_rdata");
        check_resp(in_rresp, (addr == err) ? RESP_SLVERR : RESP_OKAY, "in_rresp");
        check_last(in_rlast, beat == int'(lenw), "in_rlast");
        if (in_arready) begin
          abort_run("in_arready rose while beats of the burst were still owed");
        end
        beat++;
        cycles = 0;
      end else begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
          abort_run("timed out waiting for the next result beat");
        end
      end
      @(posedge axi_clk);
      #1;
      in_rready = ($urandom_range(99, 0) >= stall_pct);
    end
    // one cycle after the rlast handshake the port is free and silent again
    @(negedge axi_clk);
    if (!in_arready) begin
      abort_run("in_arready did not return high the cycle after the rlast beat");
    end
    if (in_rvalid) begin
      abort_run("an extra result beat came out after the rlast beat");
    end
    evens = start[0] ? (int'(lenw) + 1) / 2 : (int'(lenw) + 2) / 2;
    check_count(reads0, evens, "bank0 read count");
    check_count(reads1, int'(lenw) + 1 - evens, "bank1 read count");
    @(posedge axi_clk);
    #1;
  endtask

  initial begin
    int         fd;
    int         n;
    int         bursts;
    int         s_pct;
    string      line;
    word_addr_t s_start;
    word_addr_t s_err;
    lenw_t      s_lenw;
    void'($urandom(65));
    axi_resetn = 1'b0;
    in_araddr  = '0;
    in_arlenw  = '0;
    in_arvalid = 1'b0;
    in_rready  = 1'b0;
    err_addr   = '1;
    bursts     = 0;
    repeat (5) @(posedge axi_clk);
    #1;
    axi_resetn = 1'b1;
    // after reset the caller port is idle and both banks take responses
    @(negedge axi_clk);
    check_last(in_arready, 1'b1, "in_arready");
    check_last(in_rvalid, 1'b0, "in_rvalid");
    check_last(bank0_arvalid, 1'b0, "bank0_arvalid");
    check_last(bank1_arvalid, 1'b0, "bank1_arvalid");
    check_last(bank0_rready, 1'b1, "bank0_rready");
    check_last(bank1_rready, 1'b1, "bank1_rready");
    @(posedge axi_clk);
    #1;
    fd = $fopen("testbench/reader_stim.txt", "r");
    if (fd == 0) begin
      abort_run("could not open testbench/reader_stim.txt");
    end
    while ($fgets(line, fd) != 0) begin
      // comment lines and blank lines carry no request
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%h %d %h %d", s_start, s_lenw, s_err, s_pct);
      if (n != 4) begin
        abort_run($sformatf("could not read a request from stim line: %s", line));
      end
      run_burst(s_start, s_lenw, s_err, s_pct);
      bursts++;
    end
    $fclose(fd);
    if (bursts == 0) begin
      abort_run("the stim file held no requests");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

// File: testbench/reader_stim.txt
# start_addr(hex) lenw(dec) err_addr(hex) rready_stall_pct(dec)
# an err_addr outside the burst means every beat comes back OKAY
00000 0 fffff 0
00001 0 00001 0
00002 0 00010 30
00003 0 00100 30
00010 7 00013 0
00011 7 00011 10
00100 15 00200 25
00101 15 0010f 25
00200 1 00201 0
00201 1 00201 50
00300 31 00310 40
00401 32 00421 40
00500 63 0053e 20
01001 127 01001 60
02000 199 02063 70
02001 199 020c8 80
03000 199 03000 85
04001 199 04101 75
05000 255 050ff 50
fffe0 63 fffff 30
ffff1 30 00002 30
06000 2 06001 0
06001 2 06003 0

// File: all.f
hdl/stripe_pkg.sv
hdl/stripe_if.sv
hdl/sync_fifo.sv
hdl/bank_reader.sv
hdl/stripe_sequencer.sv
hdl/striped_reader.sv
testbench/striped_reader_chk.sv
testbench/striped_reader_tb.sv

// File: Makefile
TOP = striped_reader_tb

.PHONY: sim clean

# the run passes only when the pass message shows up in the simulator output
sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -qF "** PASS **"

clean:
	rm -rf obj_dir
